// ==== sources.f ====
+incdir+tb
hdl/dcache_pkg.sv
hdl/mem_bus_pkg.sv
hdl/sram_1rw.sv
hdl/set_state_table.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
tb/dcache_tb.sv

// ==== Makefile ====
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= Test passed

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard hdl/*.sv tb/*.sv tb/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/cache_model.svh ====
/*
 * reference model of the two-way cache and its backing memory
 * same fill-way choice, age update and write-back rule as the design
 */
`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

logic                           valid_m [2][dcache_pkg::SETS];
logic [dcache_pkg::TAG_W-1:0]   tag_m   [2][dcache_pkg::SETS];
dcache_pkg::line_t              data_m  [2][dcache_pkg::SETS];
logic                           dirty_m [2][dcache_pkg::SETS];
logic [dcache_pkg::AGE_W-1:0]   age_m   [2][dcache_pkg::SETS];
dcache_pkg::line_t              mem_m   [logic [dcache_pkg::ADDR_W-1:0]];

// contents of a line never written, built from the whole address
function automatic dcache_pkg::line_t fill_pattern(input logic [dcache_pkg::ADDR_W-1:0] addr);
    return {~addr, addr ^ 32'h9e37_79b9};
endfunction

function automatic dcache_pkg::line_t backing_read(input logic [dcache_pkg::ADDR_W-1:0] addr);
    if (mem_m.exists(addr)) begin
        return mem_m[addr];
    end
    return fill_pattern(addr);
endfunction

task automatic clear_model();
    for (int s = 0; s < dcache_pkg::SETS; s++) begin
        for (int w = 0; w < 2; w++) begin
            valid_m[w][s] = 1'b0;
            dirty_m[w][s] = 1'b0;
            age_m[w][s]   = '0;
        end
    end
endtask

// applies one access to the model and returns what the cache should do
task automatic predict_access(
    input  dcache_pkg::cpu_req_t  req,
    output logic                  hit,
    output mem_bus_pkg::mem_req_t wb_req,
    output mem_bus_pkg::mem_req_t rf_req,
    output dcache_pkg::line_t     rsp
);
    dcache_pkg::way_t               way;
    dcache_pkg::way_t               other;
    logic [dcache_pkg::INDEX_W-1:0] idx;
    dcache_pkg::addr_t              line_addr;
    logic [dcache_pkg::ADDR_W-1:0]  key;

    idx              = req.addr.index;
    line_addr        = req.addr;
    line_addr.offset = '0;
    wb_req           = '0;
    rf_req           = '0;
    hit              = 1'b1;
    if (valid_m[0][idx] && (tag_m[0][idx] == req.addr.tag)) begin
        way = 1'b0;
    end else if (valid_m[1][idx] && (tag_m[1][idx] == req.addr.tag)) begin
        way = 1'b1;
    end else begin
        hit = 1'b0;
        // empty way first, else the older one
        if (!valid_m[0][idx]) begin
            way = 1'b0;
        end else if (!valid_m[1][idx]) begin
            way = 1'b1;
        end else begin
            way = (age_m[1][idx] > age_m[0][idx]);
        end
        if (valid_m[way][idx] && dirty_m[way][idx]) begin
            wb_req.kind  = mem_bus_pkg::WRITEBACK;
            wb_req.addr  = '{tag: tag_m[way][idx], index: idx, offset: '0};
            wb_req.wdata = data_m[way][idx];
            key          = wb_req.addr;
            mem_m[key]   = data_m[way][idx];
            dirty_m[way][idx] = 1'b0;
        end
        rf_req.kind       = mem_bus_pkg::REFILL;
        rf_req.addr       = line_addr;
        key               = line_addr;
        data_m[way][idx]  = backing_read(key);
        valid_m[way][idx] = 1'b1;
        tag_m[way][idx]   = req.addr.tag;
    end
    other            = ~way;
    age_m[way][idx]  = '0;
    if (age_m[other][idx] != '1) begin
        age_m[other][idx] = age_m[other][idx] + 1'b1;
    end
    rsp = '0;
    if (req.write) begin
        for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
            if (req.strb[b]) begin
                data_m[way][idx][b*8 +: 8] = req.wdata[b*8 +: 8];
            end
        end
        dirty_m[way][idx] = 1'b1;
    end else begin
        rsp = data_m[way][idx];
    end
endtask

`endif

// ==== tb/dcache_tb.sv ====
/*
 * data cache testbench with random loads and stores over a few conflicting lines
 * memory responder with random ack delay, model compare, closing report
 */
`timescale 1ns/100ps

module dcache_tb;

    localparam int NUM_REQS   = 400;
    localparam int MAX_CYCLES = NUM_REQS * 20 + dcache_pkg::SETS + 16;

    typedef logic [dcache_pkg::TAG_W-1:0]   tag_t;
    typedef logic [dcache_pkg::INDEX_W-1:0] index_t;

    logic                  clk;
    logic                  rst_i;
    logic                  req_valid_i;
    dcache_pkg::cpu_req_t  req_i;
    logic                  req_ready_o;
    logic                  rsp_valid_o;
    dcache_pkg::line_t     rsp_data_o;
    mem_bus_pkg::mem_req_t mem_req_o;
    logic                  mem_ack_i;
    dcache_pkg::line_t     mem_rdata_i;

    int                    mismatches = 0;
    int                    failures   = 0;
    int                    cycles     = 0;
    logic                  mem_busy;
    int                    mem_delay;
    mem_bus_pkg::mem_req_t held_req;
    mem_bus_pkg::mem_req_t exp_mem [$];
    dcache_pkg::line_t     resp_mem [logic [dcache_pkg::ADDR_W-1:0]];

    `include "cache_model.svh"

    dcache_top uut (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_data_o  (rsp_data_o),
        .mem_req_o   (mem_req_o),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: run exceeded %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    task automatic note_failure(input string msg);
        failures++;
        $display("Error: %s", msg);
    endtask

    task automatic check_line(input string name, input dcache_pkg::line_t exp,
                              input dcache_pkg::line_t act);
        if (exp !== act) begin
            mismatches++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_mem_req(input string name, input mem_bus_pkg::mem_req_t exp,
                                 input mem_bus_pkg::mem_req_t act);
        if (exp !== act) begin
            mismatches++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // tag sweep keeps the core side closed
    task automatic check_init();
        int waited;
        waited = 0;
        while (!req_ready_o && (waited < dcache_pkg::SETS + 8)) begin
            if (rsp_valid_o || (mem_req_o.kind != mem_bus_pkg::NONE)) begin
                note_failure("response or memory request during the tag sweep");
            end
            @(negedge clk);
            waited++;
        end
        if (!req_ready_o) begin
            note_failure("req_ready_o did not rise after reset");
        end
    endtask

    task automatic wait_ready();
        while (!req_ready_o) begin
            @(negedge clk);
        end
        if (rsp_valid_o || (mem_req_o.kind != mem_bus_pkg::NONE)) begin
            note_failure("idle cache shows a response or a memory request");
        end
    endtask

    // one negedge of the memory side
    task automatic serve_memory(input string name);
        logic [dcache_pkg::ADDR_W-1:0] key;
        if (mem_ack_i) begin
            mem_ack_i = 1'b0;
            mem_busy  = 1'b0;
        end else if (mem_req_o.kind != mem_bus_pkg::NONE) begin
            if (!mem_busy) begin
                mem_busy  = 1'b1;
                held_req  = mem_req_o;
                mem_delay = $urandom_range(1, 6);
                if (exp_mem.size() == 0) begin
                    note_failure($sformatf("%s: unexpected memory request", name));
                end else begin
                    check_mem_req({name, " mem request"}, exp_mem.pop_front(), mem_req_o);
                end
            end else begin
                check_mem_req({name, " mem request held"}, held_req, mem_req_o);
            end
            mem_delay--;
            if (mem_delay == 0) begin
                key       = held_req.addr;
                mem_ack_i = 1'b1;
                if (held_req.kind == mem_bus_pkg::REFILL) begin
                    mem_rdata_i = resp_mem.exists(key) ? resp_mem[key] : fill_pattern(key);
                end else begin
                    resp_mem[key] = held_req.wdata;
                end
            end
        end
    endtask

    task automatic run_request(input int n, input dcache_pkg::cpu_req_t req);
        logic                  hit;
        mem_bus_pkg::mem_req_t wb_req;
        mem_bus_pkg::mem_req_t rf_req;
        dcache_pkg::line_t     exp_data;
        int                    latency;
        string                 name;

        name = $sformatf("req %0d %s", n, req.write ? "store" : "load");
        predict_access(req, hit, wb_req, rf_req, exp_data);
        exp_mem.delete();
        if (!hit) begin
            if (wb_req.kind != mem_bus_pkg::NONE) begin
                exp_mem.push_back(wb_req);
            end
            exp_mem.push_back(rf_req);
        end
        wait_ready();
        req_valid_i = 1'b1;
        req_i       = req;
        @(negedge clk);
        req_valid_i = 1'b0;
        latency     = 1;
        while (!rsp_valid_o) begin
            if (req_ready_o) begin
                note_failure($sformatf("%s: req_ready_o high before the response", name));
            end
            serve_memory(name);
            @(negedge clk);
            latency++;
        end
        check_line({name, " data"}, exp_data, rsp_data_o);
        if (hit && (latency != 2)) begin
            note_failure($sformatf("%s: hit answered after %0d cycles", name, latency));
        end
        if (exp_mem.size() != 0) begin
            note_failure($sformatf("%s: expected memory request never issued", name));
        end
    endtask

    // four tags over four sets, so ways get evicted often
    function automatic dcache_pkg::cpu_req_t random_request();
        dcache_pkg::cpu_req_t r;
        r.write       = 1'($urandom_range(0, 1));
        r.addr.tag    = tag_t'($urandom_range(0, 3) * 32'h0001_3579 + 32'h40);
        r.addr.index  = index_t'($urandom_range(0, 3) * 7 + 3);
        r.addr.offset = 3'($urandom_range(0, 7));
        r.wdata       = {$urandom, $urandom};
        r.strb        = 8'($urandom_range(1, 255));
        return r;
    endfunction

    initial begin
        dcache_pkg::cpu_req_t req;

        void'($urandom(13));
        rst_i       = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        mem_busy    = 1'b0;
        mem_delay   = 0;
        held_req    = '0;
        clear_model();
        repeat (8) @(negedge clk);
        rst_i = 1'b0;
        check_init();
        for (int n = 0; n < NUM_REQS; n++) begin
            req = random_request();
            run_request(n, req);
        end
        @(negedge clk);
        $display("%0d mismatches, %0d other errors in %0d requests",
                 mismatches, failures, NUM_REQS);
        if ((mismatches == 0) && (failures == 0)) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== hdl/dcache_top.sv ====
/*
 * two-way write-back data cache top level
 * controller, two tag RAMs, two data RAMs, set state table
 */
`timescale 1ns/100ps

module dcache_top (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  req_valid_i,
    input  dcache_pkg::cpu_req_t  req_i,
    output logic                  req_ready_o,
    output logic                  rsp_valid_o,
    output dcache_pkg::line_t     rsp_data_o,
    output mem_bus_pkg::mem_req_t mem_req_o,
    input  logic                  mem_ack_i,
    input  dcache_pkg::line_t     mem_rdata_i
);

    logic [1:0][dcache_pkg::INDEX_W-1:0] tag_addr;
    logic [1:0]                          tag_we;
    dcache_pkg::tag_entry_t [1:0]        tag_wdata;
    dcache_pkg::tag_entry_t [1:0]        tag_rdata;
    logic [1:0][dcache_pkg::INDEX_W-1:0] data_addr;
    logic [1:0]                          data_we;
    dcache_pkg::line_t [1:0]             data_wdata;
    dcache_pkg::line_t [1:0]             data_rdata;
    logic [dcache_pkg::INDEX_W-1:0]      st_index;
    logic                                touch;
    dcache_pkg::way_t                    touch_way;
    logic                                mark_dirty;
    logic                                clean;
    dcache_pkg::way_t                    clean_way;
    logic [1:0]                          dirty;
    dcache_pkg::way_t                    victim;

    dcache_ctrl #(
        .SETS(dcache_pkg::SETS)
    ) ctrl (
        .clk          (clk),
        .rst_i        (rst_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_ready_o  (req_ready_o),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_data_o   (rsp_data_o),
        .mem_req_o    (mem_req_o),
        .mem_ack_i    (mem_ack_i),
        .mem_rdata_i  (mem_rdata_i),
        .tag_addr_o   (tag_addr),
        .tag_we_o     (tag_we),
        .tag_wdata_o  (tag_wdata),
        .tag_rdata_i  (tag_rdata),
        .data_addr_o  (data_addr),
        .data_we_o    (data_we),
        .data_wdata_o (data_wdata),
        .data_rdata_i (data_rdata),
        .index_o      (st_index),
        .touch_o      (touch),
        .touch_way_o  (touch_way),
        .mark_dirty_o (mark_dirty),
        .clean_o      (clean),
        .clean_way_o  (clean_way),
        .dirty_i      (dirty),
        .victim_i     (victim)
    );

    sram_1rw #(.DEPTH(dcache_pkg::SETS), .entry_t(dcache_pkg::tag_entry_t)) tag_ram0 (
        .clk(clk), .addr_i(tag_addr[0]), .we_i(tag_we[0]),
        .wdata_i(tag_wdata[0]), .rdata_o(tag_rdata[0])
    );

    sram_1rw #(.DEPTH(dcache_pkg::SETS), .entry_t(dcache_pkg::tag_entry_t)) tag_ram1 (
        .clk(clk), .addr_i(tag_addr[1]), .we_i(tag_we[1]),
        .wdata_i(tag_wdata[1]), .rdata_o(tag_rdata[1])
    );

    sram_1rw #(.DEPTH(dcache_pkg::SETS), .entry_t(dcache_pkg::line_t)) data_ram0 (
        .clk(clk), .addr_i(data_addr[0]), .we_i(data_we[0]),
        .wdata_i(data_wdata[0]), .rdata_o(data_rdata[0])
    );

    sram_1rw #(.DEPTH(dcache_pkg::SETS), .entry_t(dcache_pkg::line_t)) data_ram1 (
        .clk(clk), .addr_i(data_addr[1]), .we_i(data_we[1]),
        .wdata_i(data_wdata[1]), .rdata_o(data_rdata[1])
    );

    set_state_table #(
        .AGE_W(dcache_pkg::AGE_W)
    ) state_table (
        .clk          (clk),
        .rst_i        (rst_i),
        .index_i      (st_index),
        .touch_i      (touch),
        .touch_way_i  (touch_way),
        .mark_dirty_i (mark_dirty),
        .clean_i      (clean),
        .clean_way_i  (clean_way),
        .dirty_o      (dirty),
        .victim_o     (victim)
    );

endmodule

// ==== hdl/dcache_ctrl.sv ====
/*
 * data cache controller FSM
 * tag sweep after reset, lookup and compare, write-back, refill and fill
 * drives both tag/data RAM pairs, the set state table and the memory port
 */
`timescale 1ns/100ps

module dcache_ctrl #(
    parameter int SETS = 64
) (
    input  logic                                      clk,
    input  logic                                      rst_i,
    input  logic                                      req_valid_i,
    input  dcache_pkg::cpu_req_t                      req_i,
    output logic                                      req_ready_o,
    output logic                                      rsp_valid_o,
    output dcache_pkg::line_t                         rsp_data_o,
    output mem_bus_pkg::mem_req_t                     mem_req_o,
    input  logic                                      mem_ack_i,
    input  dcache_pkg::line_t                         mem_rdata_i,
    output logic [1:0][dcache_pkg::INDEX_W-1:0]       tag_addr_o,
    output logic [1:0]                                tag_we_o,
    output dcache_pkg::tag_entry_t [1:0]              tag_wdata_o,
    input  dcache_pkg::tag_entry_t [1:0]              tag_rdata_i,
    output logic [1:0][dcache_pkg::INDEX_W-1:0]       data_addr_o,
    output logic [1:0]                                data_we_o,
    output dcache_pkg::line_t [1:0]                   data_wdata_o,
    input  dcache_pkg::line_t [1:0]                   data_rdata_i,
    output logic [dcache_pkg::INDEX_W-1:0]            index_o,
    output logic                                      touch_o,
    output dcache_pkg::way_t                          touch_way_o,
    output logic                                      mark_dirty_o,
    output logic                                      clean_o,
    output dcache_pkg::way_t                          clean_way_o,
    input  logic [1:0]                                dirty_i,
    input  dcache_pkg::way_t                          victim_i
);

    typedef enum logic [2:0] {
        ST_INIT,
        ST_IDLE,
        ST_LOOKUP,
        ST_COMPARE,
        ST_HIT,
        ST_WRITEBACK,
        ST_REFILL,
        ST_FILL
    } state_e;

    state_e                         state_q;
    state_e                         state_d;
    logic [dcache_pkg::INDEX_W-1:0] sweep_q;
    logic [dcache_pkg::INDEX_W-1:0] ram_index;
    dcache_pkg::cpu_req_t           req_q;
    dcache_pkg::way_t               way_q;
    dcache_pkg::addr_t              wb_addr_q;
    dcache_pkg::line_t              wb_data_q;
    dcache_pkg::line_t              fill_line_q;
    dcache_pkg::line_t              merged_line;
    dcache_pkg::tag_entry_t         new_tag;
    logic [1:0]                     hit_vec;
    logic                           hit;
    dcache_pkg::way_t               hit_way;
    dcache_pkg::way_t               fill_way;
    logic                           need_wb;
    logic                           accept;

    assign accept = req_valid_i && req_ready_o;
    assign req_ready_o = (state_q == ST_IDLE);

    // read is presented in the accept cycle straight from the request
    always_comb begin
        if (state_q == ST_INIT) begin
            ram_index = sweep_q;
        end else if (state_q == ST_IDLE) begin
            ram_index = req_i.addr.index;
        end else begin
            ram_index = req_q.addr.index;
        end
    end

    assign tag_addr_o  = {2{ram_index}};
    assign data_addr_o = {2{ram_index}};
    assign index_o     = ram_index;

    // tag compare on the RAM outputs
    assign hit_vec[0] = tag_rdata_i[0].valid && (tag_rdata_i[0].tag == req_q.addr.tag);
    assign hit_vec[1] = tag_rdata_i[1].valid && (tag_rdata_i[1].tag == req_q.addr.tag);
    assign hit        = |hit_vec;
    assign hit_way    = !hit_vec[0];

    // invalid way first, else the age victim
    always_comb begin
        if (!tag_rdata_i[0].valid) begin
            fill_way = 1'b0;
        end else if (!tag_rdata_i[1].valid) begin
            fill_way = 1'b1;
        end else begin
            fill_way = victim_i;
        end
    end

    assign need_wb = tag_rdata_i[fill_way].valid && dirty_i[fill_way];

    // store merge into the line read on the hit
    always_comb begin
        merged_line = data_rdata_i[way_q];
        for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
            if (req_q.strb[b]) begin
                merged_line[b*8 +: 8] = req_q.wdata[b*8 +: 8];
            end
        end
    end

    // sweep writes invalid entries
    assign new_tag = (state_q == ST_INIT) ? '0 : {1'b1, req_q.addr.tag};
    assign tag_wdata_o  = {2{new_tag}};
    assign data_wdata_o = (state_q == ST_HIT) ? {2{merged_line}} : {2{fill_line_q}};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= ST_INIT;
            sweep_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_INIT) begin
                sweep_q <= sweep_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_i;
        end
        if (state_q == ST_COMPARE) begin
            way_q     <= hit ? hit_way : fill_way;
            wb_addr_q <= '{tag: tag_rdata_i[fill_way].tag,
                           index: req_q.addr.index,
                           offset: '0};
            wb_data_q <= data_rdata_i[fill_way];
        end
        if ((state_q == ST_REFILL) && mem_ack_i) begin
            fill_line_q <= mem_rdata_i;
        end
    end

    always_comb begin
        state_d      = state_q;
        tag_we_o     = 2'b00;
        data_we_o    = 2'b00;
        rsp_valid_o  = 1'b0;
        rsp_data_o   = '0;
        touch_o      = 1'b0;
        touch_way_o  = way_q;
        mark_dirty_o = 1'b0;
        clean_o      = 1'b0;
        clean_way_o  = way_q;
        mem_req_o    = '0;
        case (state_q)
            ST_INIT: begin
                tag_we_o = 2'b11;
                if (sweep_q == dcache_pkg::INDEX_W'(SETS - 1)) begin
                    state_d = ST_IDLE;
                end
            end
            ST_IDLE: begin
                if (accept) begin
                    state_d = ST_COMPARE;
                end
            end
            // re-read after a fill
            ST_LOOKUP: state_d = ST_COMPARE;
            ST_COMPARE: begin
                if (hit) begin
                    state_d = ST_HIT;
                end else if (need_wb) begin
                    state_d = ST_WRITEBACK;
                end else begin
                    state_d = ST_REFILL;
                end
            end
            ST_HIT: begin
                rsp_valid_o = 1'b1;
                touch_o     = 1'b1;
                if (req_q.write) begin
                    data_we_o[way_q] = 1'b1;
                    mark_dirty_o     = 1'b1;
                end else begin
                    rsp_data_o = data_rdata_i[way_q];
                end
                state_d = ST_IDLE;
            end
            ST_WRITEBACK: begin
                mem_req_o.kind  = mem_bus_pkg::WRITEBACK;
                mem_req_o.addr  = wb_addr_q;
                mem_req_o.wdata = wb_data_q;
                if (mem_ack_i) begin
                    clean_o = 1'b1;
                    state_d = ST_REFILL;
                end
            end
            ST_REFILL: begin
                mem_req_o.kind = mem_bus_pkg::REFILL;
                mem_req_o.addr = '{tag: req_q.addr.tag, index: req_q.addr.index, offset: '0};
                if (mem_ack_i) begin
                    state_d = ST_FILL;
                end
            end
            ST_FILL: begin
                tag_we_o[way_q]  = 1'b1;
                data_we_o[way_q] = 1'b1;
                state_d          = ST_LOOKUP;
            end
            default: state_d = ST_IDLE;
        endcase
    end

endmodule

// ==== hdl/set_state_table.sv ====
/*
 * per-set dirty bits and age counters for both ways
 * victim choice from the ages of the indexed set
 */
`timescale 1ns/100ps

module set_state_table #(
    parameter int AGE_W = 3
) (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic [dcache_pkg::INDEX_W-1:0] index_i,
    input  logic                           touch_i,
    input  dcache_pkg::way_t               touch_way_i,
    input  logic                           mark_dirty_i,
    input  logic                           clean_i,
    input  dcache_pkg::way_t               clean_way_i,
    output logic [1:0]                     dirty_o,
    output dcache_pkg::way_t               victim_o
);

    localparam logic [AGE_W-1:0] AGE_MAX = '1;

    logic [AGE_W-1:0] age_q   [2][dcache_pkg::SETS];
    logic             dirty_q [2][dcache_pkg::SETS];

    dcache_pkg::way_t other_way;

    assign other_way = ~touch_way_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int s = 0; s < dcache_pkg::SETS; s++) begin
                age_q[0][s]   <= '0;
                age_q[1][s]   <= '0;
                dirty_q[0][s] <= 1'b0;
                dirty_q[1][s] <= 1'b0;
            end
        end else begin
            if (touch_i) begin
                age_q[touch_way_i][index_i] <= '0;
                // other way ages, saturating
                if (age_q[other_way][index_i] != AGE_MAX) begin
                    age_q[other_way][index_i] <= age_q[other_way][index_i] + 1'b1;
                end
            end
            if (mark_dirty_i) begin
                dirty_q[touch_way_i][index_i] <= 1'b1;
            end
            if (clean_i) begin
                dirty_q[clean_way_i][index_i] <= 1'b0;
            end
        end
    end

    assign dirty_o = {dirty_q[1][index_i], dirty_q[0][index_i]};

    // older way goes, way 0 on a tie
    assign victim_o = (age_q[1][index_i] > age_q[0][index_i]);

endmodule

// ==== hdl/sram_1rw.sv ====
/*
 * single-port synchronous RAM, registered read
 * entry type set per instance (tag entries or data lines)
 */
`timescale 1ns/100ps

module sram_1rw #(
    parameter int  DEPTH   = 64,
    parameter type entry_t = logic [63:0]
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  logic                     we_i,
    input  entry_t                   wdata_i,
    output entry_t                   rdata_o
);

    entry_t mem [DEPTH];

    // read returns the old entry when written in the same cycle
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i];
    end

endmodule

// ==== hdl/mem_bus_pkg.sv ====
/*
 * memory port request kinds and request struct
 */
package mem_bus_pkg;

    // kind stays non-NONE until the memory acks
    typedef enum logic [1:0] {
        NONE      = 2'd0,
        REFILL    = 2'd1,
        WRITEBACK = 2'd2
    } mem_kind_e;

    // addr is always line aligned, offset zero
    // wdata only meaningful for WRITEBACK
    typedef struct packed {
        mem_kind_e          kind;
        dcache_pkg::addr_t  addr;
        dcache_pkg::line_t  wdata;
    } mem_req_t;

endpackage

// ==== hdl/dcache_pkg.sv ====
/*
 * data cache geometry and address fields
 * line, tag entry and way types, core request struct
 */
package dcache_pkg;

    localparam int ADDR_W   = 32;
    localparam int TAG_W    = 23;
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 3;
    localparam int SETS     = 64;
    localparam int DATA_W   = 64;
    localparam int STRB_W   = 8;
    localparam int AGE_W    = 3;

    // physical address split, tag on top
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } addr_t;

    // one word per line
    typedef logic [DATA_W-1:0] line_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef logic way_t;

    typedef struct packed {
        logic               write;
        addr_t              addr;
        line_t              wdata;
        logic [STRB_W-1:0]  strb;
    } cpu_req_t;

endpackage
